//--- verilog/dcache_pkg.sv
package dcache_pkg;

    // line geometry
    localparam int LINE_BITS      = 6;   // 64-byte lines
    localparam int INDEX_BITS     = 6;
    localparam int TAG_BITS       = 32 - LINE_BITS - INDEX_BITS;
    localparam int WORD_BITS      = LINE_BITS - 2;
    localparam int WORDS_PER_LINE = 1 << WORD_BITS;
    localparam int NR_SETS        = 1 << INDEX_BITS;

    // one LRU bit per set only covers two ways
    localparam int NR_WAYS = 2;

    // AXI burst shape for one full line
    localparam int BURST_LEN  = WORDS_PER_LINE - 1;
    localparam int BURST_SIZE = 2;   // 4-byte beats

    localparam int DATA_ADDR_BITS = INDEX_BITS + WORD_BITS;

endpackage

//--- verilog/dcache_ram.sv
module dcache_ram #(
    parameter int DATA_BITS = 32,
    parameter int ADDR_BITS = 10
) (
    input  logic                         clk,
    input  logic [(DATA_BITS+7)/8-1:0]   we_mask,
    input  logic [ADDR_BITS-1:0]         waddr,
    input  logic [DATA_BITS-1:0]         wdata,
    input  logic [ADDR_BITS-1:0]         raddr,
    output logic [DATA_BITS-1:0]         rdata
);

    logic [DATA_BITS-1:0] mem [2**ADDR_BITS];

    // last byte lane may be partial (tag array)
    always_ff @(posedge clk) begin
        for (int i = 0; i < DATA_BITS; i++) begin
            if (we_mask[i/8]) begin
                mem[waddr][i] <= wdata[i];
            end
        end
        rdata <= mem[raddr];   // old data on a same-address write
    end

endmodule

//--- verilog/dcache_lookup.sv
module dcache_lookup (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [31:0]                          early_addr,
    input  logic                                 req_en,
    input  logic                                 req_write,
    input  logic [31:0]                          req_addr,
    input  logic [3:0]                           req_wmask,
    input  logic [31:0]                          req_wdata,
    input  logic                                 busy,
    input  logic [dcache_pkg::WORD_BITS-1:0]     rd_word,
    input  logic                                 fill_we,
    input  logic [dcache_pkg::WORD_BITS-1:0]     fill_word,
    input  logic [31:0]                          fill_wdata,
    input  logic                                 fill_start,
    input  logic                                 fill_done,
    input  logic                                 wb_done,
    output logic                                 miss,
    output logic                                 victim_way,
    output logic                                 victim_dirty,
    output logic [dcache_pkg::TAG_BITS-1:0]      victim_tag,
    output logic [31:0]                          way0_data,
    output logic [31:0]                          way1_data,
    output logic                                 hit_way,
    output logic [dcache_pkg::DATA_ADDR_BITS-1:0] last_waddr,
    output logic [3:0]                           last_we0,
    output logic [3:0]                           last_we1,
    output logic [31:0]                          last_wdata
);

    localparam int IDX_LO = dcache_pkg::LINE_BITS;
    localparam int IDX_HI = dcache_pkg::LINE_BITS + dcache_pkg::INDEX_BITS - 1;

    logic [dcache_pkg::NR_WAYS-1:0] valid [dcache_pkg::NR_SETS];
    logic [dcache_pkg::NR_WAYS-1:0] dirty [dcache_pkg::NR_SETS];
    logic                           lru   [dcache_pkg::NR_SETS];   // set = LRU way

    logic [dcache_pkg::INDEX_BITS-1:0]     idx;
    logic [dcache_pkg::INDEX_BITS-1:0]     tag_raddr;
    logic [dcache_pkg::INDEX_BITS-1:0]     rd_idx_q;
    logic [dcache_pkg::DATA_ADDR_BITS-1:0] data_raddr;
    logic [dcache_pkg::DATA_ADDR_BITS-1:0] data_waddr;
    logic [dcache_pkg::TAG_BITS-1:0]       tag0_q;
    logic [dcache_pkg::TAG_BITS-1:0]       tag1_q;
    logic [31:0]                           data_wdata;
    logic [3:0]                            we0;
    logic [3:0]                            we1;
    logic                                  hit0;
    logic                                  hit1;
    logic                                  acc;

    assign idx = req_addr[IDX_HI:IDX_LO];

    // early address while idle, so a hit needs no extra cycle
    assign tag_raddr  = busy ? idx : early_addr[IDX_HI:IDX_LO];
    assign data_raddr = busy ? {idx, rd_word} : early_addr[IDX_HI:2];

    // tags are only meaningful if they were read for this set
    assign hit0 = valid[idx][0] && tag0_q == req_addr[31:IDX_HI+1] && rd_idx_q == idx;
    assign hit1 = valid[idx][1] && tag1_q == req_addr[31:IDX_HI+1] && rd_idx_q == idx;
    assign hit_way = hit1;

    assign miss = req_en && !busy && !(hit0 || hit1);
    assign acc  = req_en && !busy && (hit0 || hit1);

    assign victim_way   = lru[idx];
    assign victim_dirty = dirty[idx][victim_way];
    assign victim_tag   = victim_way ? tag1_q : tag0_q;

    // store hits and refill beats share one write port per way
    assign we0 = (acc && req_write && hit0 ? req_wmask : 4'h0) |
                 (fill_we && !victim_way ? 4'hf : 4'h0);
    assign we1 = (acc && req_write && hit1 ? req_wmask : 4'h0) |
                 (fill_we && victim_way ? 4'hf : 4'h0);
    assign data_waddr = busy ? {idx, fill_word} : req_addr[IDX_HI:2];
    assign data_wdata = busy ? fill_wdata : req_wdata;

    dcache_ram #(.DATA_BITS(32), .ADDR_BITS(dcache_pkg::DATA_ADDR_BITS)) u_data0 (
        .clk(clk), .we_mask(we0), .waddr(data_waddr), .wdata(data_wdata),
        .raddr(data_raddr), .rdata(way0_data)
    );
    dcache_ram #(.DATA_BITS(32), .ADDR_BITS(dcache_pkg::DATA_ADDR_BITS)) u_data1 (
        .clk(clk), .we_mask(we1), .waddr(data_waddr), .wdata(data_wdata),
        .raddr(data_raddr), .rdata(way1_data)
    );
    dcache_ram #(.DATA_BITS(dcache_pkg::TAG_BITS), .ADDR_BITS(dcache_pkg::INDEX_BITS)) u_tag0 (
        .clk(clk), .we_mask({3{fill_start && !victim_way}}), .waddr(idx),
        .wdata(req_addr[31:IDX_HI+1]), .raddr(tag_raddr), .rdata(tag0_q)
    );
    dcache_ram #(.DATA_BITS(dcache_pkg::TAG_BITS), .ADDR_BITS(dcache_pkg::INDEX_BITS)) u_tag1 (
        .clk(clk), .we_mask({3{fill_start && victim_way}}), .waddr(idx),
        .wdata(req_addr[31:IDX_HI+1]), .raddr(tag_raddr), .rdata(tag1_q)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            valid    <= '{default: '0};
            dirty    <= '{default: '0};
            lru      <= '{default: 1'b0};
            rd_idx_q <= '0;
            last_we0 <= 4'h0;
            last_we1 <= 4'h0;
        end else begin
            rd_idx_q <= tag_raddr;
            last_we0 <= we0;
            last_we1 <= we1;
            if (acc) begin
                lru[idx] <= !hit_way;
                if (req_write) begin
                    dirty[idx][hit_way] <= 1'b1;
                end
            end
            if (fill_start) valid[idx][victim_way] <= 1'b0;   // old line goes away
            if (fill_done) valid[idx][victim_way] <= 1'b1;
            if (wb_done) dirty[idx][victim_way] <= 1'b0;
        end
    end

    // kept for forwarding into the next load
    always_ff @(posedge clk) begin
        last_waddr <= data_waddr;
        last_wdata <= data_wdata;
    end

    a_one_way_written: assert property (@(posedge clk) disable iff (rst)
        !((|we0) && (|we1)));

endmodule

//--- verilog/dcache_line_engine.sv
module dcache_line_engine (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [31:0]                      req_addr,
    input  logic                             pipe_stall,
    input  logic                             miss,
    input  logic                             victim_way,
    input  logic                             victim_dirty,
    input  logic [dcache_pkg::TAG_BITS-1:0]  victim_tag,
    input  logic [31:0]                      way0_data,
    input  logic [31:0]                      way1_data,
    output logic                             busy,
    output logic [dcache_pkg::WORD_BITS-1:0] rd_word,
    output logic                             fill_we,
    output logic [dcache_pkg::WORD_BITS-1:0] fill_word,
    output logic [31:0]                      fill_wdata,
    output logic                             fill_start,
    output logic                             fill_done,
    output logic                             wb_done,
    output logic                             stall,
    output logic [31:0]                      araddr,
    output logic [7:0]                       arlen,
    output logic [2:0]                       arsize,
    output logic                             arvalid,
    input  logic                             arready,
    input  logic [31:0]                      rdata,
    input  logic                             rlast,
    input  logic                             rvalid,
    output logic                             rready,
    output logic [31:0]                      awaddr,
    output logic [7:0]                       awlen,
    output logic [2:0]                       awsize,
    output logic                             awvalid,
    input  logic                             awready,
    output logic [31:0]                      wdata,
    output logic [3:0]                       wstrb,
    output logic                             wlast,
    output logic                             wvalid,
    input  logic                             wready,
    input  logic                             bvalid
);

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_VREAD  = 2'd1;   // copy victim into vbuf
    localparam logic [1:0] S_XFER   = 2'd2;
    localparam logic [1:0] S_REREAD = 2'd3;

    localparam int WB = dcache_pkg::WORD_BITS;

    logic [1:0]    state;
    logic [WB:0]   vcnt;
    logic [WB-1:0] rcnt;
    logic [WB-1:0] wcnt;
    logic [31:0]   vbuf [dcache_pkg::WORDS_PER_LINE];
    logic          wb_pend;
    logic          held_q;   // request already served during pipe_stall

    assign busy       = state != S_IDLE;
    assign fill_start = state == S_IDLE && miss && !held_q;
    assign stall      = busy || fill_start;
    assign rd_word    = state == S_VREAD ? vcnt[WB-1:0] : req_addr[dcache_pkg::LINE_BITS-1:2];

    assign fill_we    = state == S_XFER && rvalid && rready;
    assign fill_word  = rcnt;
    assign fill_wdata = rdata;
    assign wb_done    = state == S_XFER && wb_pend && bvalid;
    // both bursts finished, possibly in this very cycle
    assign fill_done  = state == S_XFER && (!rready || (rvalid && rlast)) &&
                        (!wb_pend || bvalid);

    assign arlen  = 8'(dcache_pkg::BURST_LEN);
    assign awlen  = 8'(dcache_pkg::BURST_LEN);
    assign arsize = 3'(dcache_pkg::BURST_SIZE);
    assign awsize = 3'(dcache_pkg::BURST_SIZE);
    assign wstrb  = 4'hf;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_IDLE;
            arvalid <= 1'b0;
            rready  <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            wlast   <= 1'b0;
            wb_pend <= 1'b0;
            held_q  <= 1'b0;
        end else begin
            held_q <= pipe_stall && !stall;
            case (state)
                S_IDLE: begin
                    if (fill_start) begin
                        araddr <= {req_addr[31:dcache_pkg::LINE_BITS], {dcache_pkg::LINE_BITS{1'b0}}};
                        awaddr <= {victim_tag, req_addr[dcache_pkg::LINE_BITS+dcache_pkg::INDEX_BITS-1:
                                   dcache_pkg::LINE_BITS], {dcache_pkg::LINE_BITS{1'b0}}};
                        vcnt <= '0;
                        rcnt <= '0;
                        wcnt <= '0;
                        if (victim_dirty) begin
                            state   <= S_VREAD;
                            wb_pend <= 1'b1;
                        end else begin
                            state   <= S_XFER;
                            arvalid <= 1'b1;
                            rready  <= 1'b1;
                        end
                    end
                end
                S_VREAD: begin
                    vcnt <= vcnt + 1'b1;
                    if (vcnt != 0) begin
                        vbuf[vcnt[WB-1:0] - 1'b1] <= victim_way ? way1_data : way0_data;
                    end
                    if (vcnt == dcache_pkg::WORDS_PER_LINE) begin
                        state   <= S_XFER;
                        arvalid <= 1'b1;
                        rready  <= 1'b1;
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        wdata   <= vbuf[0];
                        wlast   <= 1'b0;
                    end
                end
                S_XFER: begin
                    if (arvalid && arready) arvalid <= 1'b0;
                    if (awvalid && awready) awvalid <= 1'b0;
                    if (rvalid && rready) begin
                        rcnt <= rcnt + 1'b1;
                        if (rlast) rready <= 1'b0;
                    end
                    if (wvalid && wready) begin
                        if (wlast) begin
                            wvalid <= 1'b0;
                        end else begin
                            wdata <= vbuf[wcnt + 1'b1];
                            wcnt  <= wcnt + 1'b1;
                            wlast <= wcnt == WB'(dcache_pkg::BURST_LEN - 1);
                        end
                    end
                    if (bvalid) wb_pend <= 1'b0;
                    if (fill_done) state <= S_REREAD;
                end
                default: state <= S_IDLE;   // re-read of the requested word
            endcase
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr));
    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr));
    // rlast must come with the last word of the line
    a_fill_last: assert property (@(posedge clk) disable iff (rst)
        fill_we && rlast |-> rcnt == WB'(dcache_pkg::BURST_LEN));

endmodule

//--- verilog/dcache_result.sv
module dcache_result (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  req_en,
    input  logic [31:0]                           req_addr,
    input  logic                                  pipe_stall,
    input  logic                                  stall,
    input  logic [31:0]                           way0_data,
    input  logic [31:0]                           way1_data,
    input  logic                                  hit_way,
    input  logic [dcache_pkg::DATA_ADDR_BITS-1:0] last_waddr,
    input  logic [3:0]                            last_we0,
    input  logic [3:0]                            last_we1,
    input  logic [31:0]                           last_wdata,
    output logic [31:0]                           rdata
);

    logic [31:0] sel_data;
    logic [3:0]  sel_we;
    logic [31:0] bit_mask;
    logic [31:0] fwd_data;
    logic        hold_q;
    logic [31:0] hold_data;

    assign sel_data = hit_way ? way1_data : way0_data;
    assign sel_we   = hit_way ? last_we1 : last_we0;
    assign bit_mask = {{8{sel_we[3]}}, {8{sel_we[2]}}, {8{sel_we[1]}}, {8{sel_we[0]}}};

    // array read missed the store of the previous cycle
    assign fwd_data = last_waddr == req_addr[dcache_pkg::LINE_BITS+dcache_pkg::INDEX_BITS-1:2]
                    ? (last_wdata & bit_mask) | (sel_data & ~bit_mask)
                    : sel_data;

    assign rdata = hold_q ? hold_data : fwd_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            hold_q <= 1'b0;
        end else if (!hold_q && req_en && !stall && pipe_stall) begin
            hold_q <= 1'b1;
        end else if (!pipe_stall) begin
            hold_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_q) hold_data <= fwd_data;   // only read back while hold_q
    end

endmodule

//--- verilog/dcache_top.sv
module dcache_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] early_addr,
    input  logic        req_en,
    input  logic        req_write,
    input  logic [31:0] req_addr,
    input  logic [3:0]  req_wmask,
    input  logic [31:0] req_wdata,
    input  logic        pipe_stall,
    output logic        stall,
    output logic [31:0] rdata,
    output logic [31:0] araddr,
    output logic [7:0]  arlen,
    output logic [2:0]  arsize,
    output logic        arvalid,
    input  logic        arready,
    input  logic [31:0] axi_rdata,
    input  logic        rlast,
    input  logic        rvalid,
    output logic        rready,
    output logic [31:0] awaddr,
    output logic [7:0]  awlen,
    output logic [2:0]  awsize,
    output logic        awvalid,
    input  logic        awready,
    output logic [31:0] wdata,
    output logic [3:0]  wstrb,
    output logic        wlast,
    output logic        wvalid,
    input  logic        wready,
    input  logic        bvalid,
    output logic        bready
);

    logic                                  miss;
    logic                                  victim_way;
    logic                                  victim_dirty;
    logic [dcache_pkg::TAG_BITS-1:0]       victim_tag;
    logic [31:0]                           way0_data;
    logic [31:0]                           way1_data;
    logic                                  hit_way;
    logic [dcache_pkg::DATA_ADDR_BITS-1:0] last_waddr;
    logic [3:0]                            last_we0;
    logic [3:0]                            last_we1;
    logic [31:0]                           last_wdata;
    logic                                  busy;
    logic [dcache_pkg::WORD_BITS-1:0]      rd_word;
    logic                                  fill_we;
    logic [dcache_pkg::WORD_BITS-1:0]      fill_word;
    logic [31:0]                           fill_wdata;
    logic                                  fill_start;
    logic                                  fill_done;
    logic                                  wb_done;

    assign bready = 1'b1;   // write responses always taken

    dcache_lookup u_lookup (
        .clk(clk), .rst(rst), .early_addr(early_addr), .req_en(req_en),
        .req_write(req_write), .req_addr(req_addr), .req_wmask(req_wmask),
        .req_wdata(req_wdata), .busy(busy), .rd_word(rd_word), .fill_we(fill_we),
        .fill_word(fill_word), .fill_wdata(fill_wdata), .fill_start(fill_start),
        .fill_done(fill_done), .wb_done(wb_done), .miss(miss), .victim_way(victim_way),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag), .way0_data(way0_data),
        .way1_data(way1_data), .hit_way(hit_way), .last_waddr(last_waddr),
        .last_we0(last_we0), .last_we1(last_we1), .last_wdata(last_wdata)
    );

    dcache_line_engine u_engine (
        .clk(clk), .rst(rst), .req_addr(req_addr), .pipe_stall(pipe_stall), .miss(miss),
        .victim_way(victim_way), .victim_dirty(victim_dirty), .victim_tag(victim_tag),
        .way0_data(way0_data), .way1_data(way1_data), .busy(busy), .rd_word(rd_word),
        .fill_we(fill_we), .fill_word(fill_word), .fill_wdata(fill_wdata),
        .fill_start(fill_start), .fill_done(fill_done), .wb_done(wb_done), .stall(stall),
        .araddr(araddr), .arlen(arlen), .arsize(arsize), .arvalid(arvalid),
        .arready(arready), .rdata(axi_rdata), .rlast(rlast), .rvalid(rvalid),
        .rready(rready), .awaddr(awaddr), .awlen(awlen), .awsize(awsize),
        .awvalid(awvalid), .awready(awready), .wdata(wdata), .wstrb(wstrb),
        .wlast(wlast), .wvalid(wvalid), .wready(wready), .bvalid(bvalid)
    );

    dcache_result u_result (
        .clk(clk), .rst(rst), .req_en(req_en), .req_addr(req_addr),
        .pipe_stall(pipe_stall), .stall(stall), .way0_data(way0_data),
        .way1_data(way1_data), .hit_way(hit_way), .last_waddr(last_waddr),
        .last_we0(last_we0), .last_we1(last_we1), .last_wdata(last_wdata), .rdata(rdata)
    );

endmodule

//--- verif/tb_clock.sv
module tb_clock #(
    parameter int PERIOD = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

//--- verif/axi_mem_model.sv
module axi_mem_model #(
    parameter int ADDR_BITS = 14   // word address width
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] araddr,
    input  logic [7:0]  arlen,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wlast,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    input  logic        bready
);

    logic [31:0] mem [2**ADDR_BITS];
    logic [1:0]  phase = 2'd0;   // readies drop once every three cycles
    logic        rd_active = 1'b0;
    logic [31:0] rd_addr = '0;
    logic [7:0]  rd_left = '0;
    logic        wr_active = 1'b0;
    logic [31:0] wr_addr = '0;
    logic        b_q = 1'b0;

    initial begin
        for (int i = 0; i < 2**ADDR_BITS; i++) begin
            mem[i] = 32'(i * 4) ^ 32'h5A5A0000;
        end
    end

    assign arready = !rd_active && phase != 2'd2;
    assign awready = !wr_active && phase != 2'd2;
    assign wready  = wr_active && phase != 2'd0;   // data only after the address
    assign rvalid  = rd_active;
    assign rdata   = mem[rd_addr[ADDR_BITS+1:2]];
    assign rlast   = rd_left == 8'd0;
    assign bvalid  = b_q;

    always @(posedge clk) begin
        if (rst) begin
            phase     <= 2'd0;
            rd_active <= 1'b0;
            wr_active <= 1'b0;
            b_q       <= 1'b0;
        end else begin
            phase <= phase == 2'd2 ? 2'd0 : phase + 2'd1;
            if (arvalid && arready) begin
                rd_active <= 1'b1;
                rd_addr   <= araddr;
                rd_left   <= arlen;
            end
            if (rvalid && rready) begin
                rd_addr <= rd_addr + 32'd4;
                rd_left <= rd_left - 8'd1;
                if (rlast) rd_active <= 1'b0;
            end
            if (awvalid && awready) begin
                wr_active <= 1'b1;
                wr_addr   <= awaddr;
            end
            if (wvalid && wready) begin
                mem[wr_addr[ADDR_BITS+1:2]] <= wdata;
                wr_addr <= wr_addr + 32'd4;
                if (wlast) begin
                    wr_active <= 1'b0;
                    b_q       <= 1'b1;
                end
            end
            if (b_q && bready) b_q <= 1'b0;
        end
    end

endmodule

//--- verif/dcache_tb.sv
module dcache_tb;

    localparam int RESET_CYCLES = 16;
    localparam int NR_RANDOM    = 300;
    localparam int NR_DIRECTED  = 15;
    localparam int NR_ACCESSES  = NR_DIRECTED + NR_RANDOM;
    localparam int MEM_BITS     = 14;   // 64 KiB behind the bus

    logic        clk;
    logic        rst;
    logic [31:0] early_addr;
    logic        req_en;
    logic        req_write;
    logic [31:0] req_addr;
    logic [3:0]  req_wmask;
    logic [31:0] req_wdata;
    logic        pipe_stall;
    logic        stall;
    logic [31:0] rdata;
    logic [31:0] araddr;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic        arvalid;
    logic        arready;
    logic [31:0] axi_rdata;
    logic        rlast;
    logic        rvalid;
    logic        rready;
    logic [31:0] awaddr;
    logic [7:0]  awlen;
    logic [2:0]  awsize;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wlast;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;

    logic [31:0] ref_mem [2**MEM_BITS];
    logic [31:0] rng = 32'd47410;
    int          errors = 0;
    int          ar_count = 0;
    int          aw_count = 0;
    logic [31:0] ar_seen_addr;
    logic [7:0]  ar_seen_len;
    logic [2:0]  ar_seen_size;
    logic [31:0] aw_seen_addr;
    logic [7:0]  aw_seen_len;
    logic [2:0]  aw_seen_size;
    logic [31:0] wbeats [$];
    logic [3:0]  wstrbs [$];

    tb_clock #(.PERIOD(10)) u_clock (.clk(clk));

    dcache_top u_dcache_top (.*);

    axi_mem_model #(.ADDR_BITS(MEM_BITS)) u_mem (
        .clk(clk), .rst(rst), .araddr(araddr), .arlen(arlen), .arvalid(arvalid),
        .arready(arready), .rdata(axi_rdata), .rlast(rlast), .rvalid(rvalid),
        .rready(rready), .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wlast(wlast), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready)
    );

    // bus handshakes, sampled mid-cycle
    always @(negedge clk) begin
        if (arvalid && arready) begin
            ar_seen_addr <= araddr;
            ar_seen_len  <= arlen;
            ar_seen_size <= arsize;
            ar_count     <= ar_count + 1;
        end
        if (awvalid && awready) begin
            aw_seen_addr <= awaddr;
            aw_seen_len  <= awlen;
            aw_seen_size <= awsize;
            aw_count     <= aw_count + 1;
        end
        if (wvalid && wready) begin
            wbeats.push_back(wdata);
            wstrbs.push_back(wstrb);
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int idx, input int word);
        return 32'((tag << 12) | (idx << 6) | (word << 2));
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("** Error @%0t: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1, "stopping at the first failed check");
    endtask

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp)
        else report_error($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    task automatic ref_write(input logic [31:0] addr, input logic [3:0] mask,
                             input logic [31:0] data);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) ref_mem[addr[MEM_BITS+1:2]][8*b +: 8] = data[8*b +: 8];
        end
    endtask

    task automatic present(input logic [31:0] addr, input logic wr, input logic [3:0] mask,
                           input logic [31:0] data);
        @(posedge clk);
        req_en     <= 1'b1;
        req_write  <= wr;
        req_addr   <= addr;
        req_wmask  <= mask;
        req_wdata  <= data;
        early_addr <= addr;
    endtask

    // rdata of the first cycle with stall low
    task automatic wait_done(output logic [31:0] got, output int waited);
        waited = 0;
        @(negedge clk);
        while (stall) begin
            waited++;
            @(negedge clk);
        end
        got = rdata;
    endtask

    task automatic access(input logic [31:0] addr, input logic wr, input logic [3:0] mask,
                          input logic [31:0] data, output logic [31:0] got,
                          output int waited);
        @(posedge clk);
        req_en     <= 1'b0;
        early_addr <= addr;   // arrays read one cycle ahead
        present(addr, wr, mask, data);
        wait_done(got, waited);
    endtask

    task automatic load_check(input logic [31:0] addr, output int waited);
        logic [31:0] got;
        access(addr, 1'b0, 4'h0, 32'h0, got, waited);
        check_word($sformatf("load %h", addr), got, ref_mem[addr[MEM_BITS+1:2]]);
    endtask

    task automatic store(input logic [31:0] addr, input logic [3:0] mask,
                         input logic [31:0] data);
        logic [31:0] got;
        int          waited;
        access(addr, 1'b1, mask, data, got, waited);
        ref_write(addr, mask, data);
    endtask

    task automatic cold_read_miss();
        logic [31:0] addr;
        int          waited;
        int          ar_before;
        addr = make_addr(3, 5, 7);
        ar_before = ar_count;
        load_check(addr, waited);
        assert (waited > 0) else report_error("load of a cold line never raised stall");
        check_word("read bursts", 32'(ar_count - ar_before), 32'd1);
        check_word("arlen", 32'(ar_seen_len), 32'd15);
        check_word("arsize", 32'(ar_seen_size), 32'd2);   // 4-byte beats
        check_word("araddr", ar_seen_addr, {addr[31:6], 6'b0});
    endtask

    task automatic warm_read_hit();
        int waited;
        int ar_before;
        ar_before = ar_count;
        load_check(make_addr(3, 5, 12), waited);
        assert (waited == 0) else report_error("load of a cached line raised stall");
        check_word("read bursts", 32'(ar_count - ar_before), 32'd0);
    endtask

    task automatic store_then_forward();
        logic [31:0] addr;
        logic [31:0] got;
        int          waited;
        addr = make_addr(3, 5, 9);
        store(addr, 4'b0101, 32'hA1B2C3D4);
        present(addr, 1'b0, 4'h0, 32'h0);   // same word, next cycle
        wait_done(got, waited);
        check_word("forwarded load", got, ref_mem[addr[MEM_BITS+1:2]]);
        assert (waited == 0) else report_error("forwarded load raised stall");
        load_check(addr, waited);
    endtask

    task automatic dirty_eviction();
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] a2;
        int          waited;
        int          aw_before;
        a0 = make_addr(1, 20, 0);
        a1 = make_addr(2, 20, 0);
        a2 = make_addr(4, 20, 0);
        store(a0, 4'hf, 32'h0BAD0001);
        store(a0 + 20, 4'b1100, 32'hCAFE0000);
        store(a1 + 12, 4'hf, 32'h12345678);
        store(a1 + 60, 4'b0011, 32'h0000BEEF);
        load_check(a0 + 20, waited);   // a1 line is now LRU
        aw_before = aw_count;
        wbeats.delete();
        wstrbs.delete();
        store(a2 + 8, 4'hf, 32'h76543210);
        check_word("write bursts", 32'(aw_count - aw_before), 32'd1);
        check_word("awaddr", aw_seen_addr, a1);
        check_word("awlen", 32'(aw_seen_len), 32'd15);
        check_word("awsize", 32'(aw_seen_size), 32'd2);
        check_word("write beats", 32'(wbeats.size()), 32'd16);
        for (int k = 0; k < 16; k++) begin
            check_word($sformatf("write beat %0d", k), wbeats[k],
                       ref_mem[a1[MEM_BITS+1:2] + k]);
            check_word($sformatf("wstrb of beat %0d", k), 32'(wstrbs[k]), 32'hf);
        end
        load_check(a1 + 12, waited);
        load_check(a1 + 60, waited);
    endtask

    task automatic pipeline_hold();
        logic [31:0] addr;
        logic [31:0] exp;
        int          waited;
        addr = make_addr(3, 5, 12);
        load_check(addr, waited);
        exp = ref_mem[addr[MEM_BITS+1:2]];
        @(posedge clk);
        req_en     <= 1'b0;
        early_addr <= addr;
        present(addr, 1'b0, 4'h0, 32'h0);
        pipe_stall <= 1'b1;
        early_addr <= make_addr(2, 33, 1);   // next load in another set
        repeat (5) begin
            @(negedge clk);
            check_word("held load", rdata, exp);
            assert (!stall) else report_error("stall rose while the pipeline was held");
        end
        @(posedge clk);
        pipe_stall <= 1'b0;
        req_en     <= 1'b0;
    endtask

    task automatic random_traffic();
        logic [31:0] addr;
        int          waited;
        for (int n = 0; n < NR_RANDOM; n++) begin
            rng  = xorshift(rng);
            addr = make_addr(int'(rng[7:0]) % 6, 40 + int'(rng[9:8]), int'(rng[13:10]));
            if (rng[16]) begin
                rng = xorshift(rng);
                store(addr, rng[3:0], rng);
            end else begin
                load_check(addr, waited);
            end
        end
    endtask

    initial begin
        rst        = 1'b1;
        early_addr = '0;
        req_en     = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_wmask  = '0;
        req_wdata  = '0;
        pipe_stall = 1'b0;
        for (int i = 0; i < 2**MEM_BITS; i++) begin
            ref_mem[i] = 32'(i * 4) ^ 32'h5A5A0000;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        cold_read_miss();
        warm_read_hit();
        store_then_forward();
        dirty_eviction();
        pipeline_hold();
        random_traffic();
        @(posedge clk);
        req_en <= 1'b0;
        repeat (2) @(posedge clk);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // worst case per access covers a dirty miss with a slow bus
    initial begin
        repeat (RESET_CYCLES + 200 * NR_ACCESSES) @(posedge clk);
        $display("Finished with errors");
        $fatal(1, "timeout: tests still running after %0d cycles",
               RESET_CYCLES + 200 * NR_ACCESSES);
    end

endmodule

//--- dcache.f
verilog/dcache_pkg.sv
verilog/dcache_ram.sv
verilog/dcache_lookup.sv
verilog/dcache_line_engine.sv
verilog/dcache_result.sv
verilog/dcache_top.sv
verif/tb_clock.sv
verif/axi_mem_model.sv
verif/dcache_tb.sv
